// File: src.f
trs_dbg_pkg.sv
bus_access_filter.sv
spi_byte_link.sv
cmd_decoder.sv
breakpoint_slot.sv
xray_control.sv
trs_dbg_top.sv
tb_trs_dbg.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = tb_trs_dbg
FILELIST  = src.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

// File: tb_trs_dbg.sv
module tb_trs_dbg;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_SCK = 8;                      // clk cycles per sck half period
  localparam int WAIT_MAX = 100;                    // halted wait limit, clk cycles
  localparam logic [31:0] SEED = 32'hbc46_3332;

  // host command codes
  localparam logic [7:0] C_COOKIE  = 8'd0;
  localparam logic [7:0] C_SET     = 8'd6;
  localparam logic [7:0] C_CLEAR   = 8'd7;
  localparam logic [7:0] C_ENABLE  = 8'd11;
  localparam logic [7:0] C_DISABLE = 8'd12;
  localparam logic [7:0] C_RESUME  = 8'd13;
  localparam logic [7:0] C_VERSION = 8'd15;
  localparam logic [7:0] C_ABUS    = 8'd18;

  typedef enum logic [1:0] {SPI_CMD, BUS_READ, BUS_GLITCH} kind_t;

  typedef struct packed {
    kind_t          kind;
    logic [2:0]     nbytes;
    logic [3:0][7:0] seq;                           // sent from seq[0] upward
    logic [15:0]    addr;
    logic           chk_resp;
    logic [7:0]     exp_resp;
    logic           exp_halted;
    logic [2:0]     exp_hit;
  } row_t;

  logic        clk, rst_n;
  logic        sck, cs_n, mosi, miso;
  logic [15:0] addr;
  logic        rd_n;
  logic        halted;
  logic [2:0]  hit_index;

  row_t  rows [$];
  string names [$];
  int    errors;
  int    checks;

  trs_dbg_top dut (
    .clk(clk), .rst_n(rst_n), .sck(sck), .cs_n(cs_n), .mosi(mosi),
    .addr(addr), .rd_n(rd_n), .miso(miso), .halted(halted), .hit_index(hit_index)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;                          // 10 ns
  end

  function automatic void add_spi(string name, int n, logic [3:0][7:0] seq, logic chk,
                                  logic [7:0] resp, logic hlt, logic [2:0] hit);
    row_t r;
    r = '{kind: SPI_CMD, nbytes: 3'(n), seq: seq, addr: '0, chk_resp: chk,
          exp_resp: resp, exp_halted: hlt, exp_hit: hit};
    rows.push_back(r);
    names.push_back(name);
  endfunction

  function automatic void add_bus(string name, kind_t kind, logic [15:0] a,
                                  logic hlt, logic [2:0] hit);
    row_t r;
    r = '{kind: kind, nbytes: '0, seq: '0, addr: a, chk_resp: 1'b0,
          exp_resp: '0, exp_halted: hlt, exp_hit: hit};
    rows.push_back(r);
    names.push_back(name);
  endfunction

  // one byte, msb first, miso taken while sck is high
  task automatic send_byte(input logic [7:0] tx, output logic [7:0] rx);
    rx = '0;
    for (int i = 7; i >= 0; i--) begin
      @(posedge clk);
      mosi <= tx[i];                                // change while sck low
      repeat (HALF_SCK) @(posedge clk);
      sck <= 1'b1;
      @(negedge clk);
      rx = {rx[6:0], miso};
      repeat (HALF_SCK) @(posedge clk);
      sck <= 1'b0;
    end
  endtask

  // whole cs_n frame, one dummy byte appended when a response is due
  task automatic spi_frame(input row_t r, output logic [7:0] resp);
    logic [7:0] rx;
    @(posedge clk);
    cs_n <= 1'b0;
    repeat (HALF_SCK) @(posedge clk);
    for (int i = 0; i < int'(r.nbytes); i++) begin
      send_byte(r.seq[i], rx);
    end
    resp = '0;
    if (r.chk_resp) send_byte(8'h00, resp);
    repeat (HALF_SCK) @(posedge clk);
    cs_n <= 1'b1;
    repeat (HALF_SCK) @(posedge clk);               // gap between frames
  endtask

  // rd_n low for low_cycles, then idle for 20
  task automatic bus_cycle(input logic [15:0] a, input int low_cycles);
    @(posedge clk);
    addr <= a;
    rd_n <= 1'b0;
    repeat (low_cycles) @(posedge clk);
    rd_n <= 1'b1;
    repeat (20) @(posedge clk);
  endtask

  task automatic wait_halted(input logic level, input string name);
    int n;
    n = 0;
    @(negedge clk);
    while (halted !== level && n < WAIT_MAX) begin
      @(negedge clk);
      n++;
    end
    if (halted !== level) begin
      errors++;
      $display("Timeout in %s: halted did not go to %0b within %0d cycles",
               name, level, WAIT_MAX);
    end
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [15:0] exp, input logic [15:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("Error: %s %s expected %0h actual %0h", name, what, exp, act);
    end
  endtask

  initial begin
    logic [15:0] addr_a, addr_b, addr_o, addr_r;
    logic [2:0]  slot_a, slot_b, slot_lo, slot_hi;
    logic [31:0] rnd;
    logic [7:0]  got;
    row_t        r;

    rst_n  = 1'b0;
    sck    = 1'b0;
    cs_n   = 1'b1;
    mosi   = 1'b0;
    addr   = '0;
    rd_n   = 1'b1;
    errors = 0;
    checks = 0;

    void'($urandom(SEED));
    addr_a = 16'($urandom);
    rnd    = $urandom;
    addr_b = addr_a + 16'd1 + 16'(rnd % 1000);      // never equal to addr_a
    addr_o = addr_a ^ 16'h8000;                     // far from both
    addr_r = 16'($urandom);
    rnd    = $urandom;
    slot_a = rnd[2:0];
    rnd    = $urandom;
    slot_b = slot_a + 3'd1 + 3'(rnd % 7);           // distinct slot
    slot_lo = (slot_a < slot_b) ? slot_a : slot_b;
    slot_hi = (slot_a < slot_b) ? slot_b : slot_a;

    // identification and bus snoop
    add_spi("cookie", 1, {24'h0, C_COOKIE}, 1'b1, 8'haf, 1'b0, 3'd0);
    add_spi("version", 1, {24'h0, C_VERSION}, 1'b1, 8'h03, 1'b0, 3'd0);
    add_bus("snoop_read", BUS_READ, addr_r, 1'b0, 3'd0);
    add_spi("abus_read", 1, {24'h0, C_ABUS}, 1'b1, addr_r[7:0], 1'b0, 3'd0);
    // armed while disabled, enabled first so disable has to clear it
    add_spi("enable_early", 1, {24'h0, C_ENABLE}, 1'b0, 8'h00, 1'b0, 3'd0);
    add_spi("disable", 1, {24'h0, C_DISABLE}, 1'b0, 8'h00, 1'b0, 3'd0);
    add_spi("set_a", 4, {addr_a[15:8], addr_a[7:0], 5'd0, slot_a, C_SET}, 1'b0, 8'h00,
            1'b0, 3'd0);
    add_spi("set_b", 4, {addr_b[15:8], addr_b[7:0], 5'd0, slot_b, C_SET}, 1'b0, 8'h00,
            1'b0, 3'd0);
    add_bus("read_a_disabled", BUS_READ, addr_a, 1'b0, 3'd0);
    add_bus("read_b_disabled", BUS_READ, addr_b, 1'b0, 3'd0);
    // enabled, stop and resume
    add_spi("enable", 1, {24'h0, C_ENABLE}, 1'b0, 8'h00, 1'b0, 3'd0);
    add_bus("hit_b", BUS_READ, addr_b, 1'b1, slot_b);
    add_bus("read_a_stopped", BUS_READ, addr_a, 1'b1, slot_b);
    add_bus("read_o_stopped", BUS_READ, addr_o, 1'b1, slot_b);
    add_spi("resume", 1, {24'h0, C_RESUME}, 1'b0, 8'h00, 1'b1, slot_b);
    add_bus("read_o_resuming", BUS_READ, addr_o, 1'b1, slot_b);
    add_bus("refetch_b", BUS_READ, addr_b, 1'b0, slot_b);
    // clear, then two slots on one address
    add_spi("clear_b", 2, {16'h0, 5'd0, slot_b, C_CLEAR}, 1'b0, 8'h00, 1'b0, slot_b);
    add_bus("read_b_cleared", BUS_READ, addr_b, 1'b0, slot_b);
    add_spi("set_hi", 4, {addr_o[15:8], addr_o[7:0], 5'd0, slot_hi, C_SET}, 1'b0, 8'h00,
            1'b0, slot_b);
    add_spi("set_lo", 4, {addr_o[15:8], addr_o[7:0], 5'd0, slot_lo, C_SET}, 1'b0, 8'h00,
            1'b0, slot_b);
    add_bus("hit_shared", BUS_READ, addr_o, 1'b1, slot_lo);
    add_spi("resume_2", 1, {24'h0, C_RESUME}, 1'b0, 8'h00, 1'b1, slot_lo);
    add_bus("refetch_o", BUS_READ, addr_o, 1'b0, slot_lo);
    // short rd_n pulse is filtered out
    add_bus("glitch_o", BUS_GLITCH, addr_o, 1'b0, slot_lo);
    add_bus("hit_after_glitch", BUS_READ, addr_o, 1'b1, slot_lo);

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk);

    for (int i = 0; i < rows.size(); i++) begin
      r = rows[i];
      got = '0;
      case (r.kind)
        SPI_CMD:  spi_frame(r, got);
        BUS_READ: bus_cycle(r.addr, 20);
        default:  bus_cycle(r.addr, 2);             // shorter than the filter
      endcase
      if (r.chk_resp) check_value(names[i], "response", 16'(r.exp_resp), 16'(got));
      wait_halted(r.exp_halted, names[i]);
      check_value(names[i], "halted", 16'(r.exp_halted), 16'(halted));
      check_value(names[i], "hit_index", 16'(r.exp_hit), 16'(hit_index));
    end

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: trs_dbg_top.sv
module trs_dbg_top import trs_dbg_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                sck,
  input  logic                cs_n,
  input  logic                mosi,
  input  logic [ADDR_W-1:0]   addr,
  input  logic                rd_n,
  output logic                miso,
  output logic                halted,
  output logic [BP_IDX_W-1:0] hit_index
);

  // spi link <-> decoder
  logic [BYTE_W-1:0]   rx_byte;
  logic                rx_valid;
  logic                frame_start;
  logic [BYTE_W-1:0]   tx_byte;
  logic                tx_load;

  // bus side
  logic                read_strobe;
  logic [ADDR_W-1:0]   read_addr;

  // breakpoint control
  logic                bp_set, bp_clear;
  logic [BP_IDX_W-1:0] bp_sel;
  logic [ADDR_W-1:0]   bp_addr;
  logic                bp_enable;
  logic                resume_req;
  logic [NUM_BP-1:0]   match;

  spi_byte_link u_link (
    .clk(clk), .rst_n(rst_n), .sck(sck), .cs_n(cs_n), .mosi(mosi),
    .tx_byte(tx_byte), .tx_load(tx_load), .rx_byte(rx_byte),
    .rx_valid(rx_valid), .frame_start(frame_start), .miso(miso)
  );

  cmd_decoder u_dec (
    .clk(clk), .rst_n(rst_n), .rx_byte(rx_byte), .rx_valid(rx_valid),
    .frame_start(frame_start), .read_addr(read_addr), .tx_byte(tx_byte),
    .tx_load(tx_load), .bp_set(bp_set), .bp_clear(bp_clear), .bp_sel(bp_sel),
    .bp_addr(bp_addr), .bp_enable(bp_enable), .resume_req(resume_req)
  );

  bus_access_filter u_bus (
    .clk(clk), .rst_n(rst_n), .addr(addr), .rd_n(rd_n),
    .read_strobe(read_strobe), .read_addr(read_addr)
  );

  for (genvar i = 0; i < NUM_BP; i++) begin : g_slot
    breakpoint_slot u_slot (
      .clk(clk), .rst_n(rst_n), .slot_id(BP_IDX_W'(i)), .bp_set(bp_set),
      .bp_clear(bp_clear), .bp_sel(bp_sel), .bp_addr(bp_addr),
      .read_addr(read_addr), .match(match[i])
    );
  end

  xray_control u_xray (
    .clk(clk), .rst_n(rst_n), .match(match), .read_strobe(read_strobe),
    .read_addr(read_addr), .bp_enable(bp_enable), .resume_req(resume_req),
    .halted(halted), .hit_index(hit_index)
  );

endmodule

// File: xray_control.sv
module xray_control import trs_dbg_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [NUM_BP-1:0]   match,
  input  logic                read_strobe,
  input  logic [ADDR_W-1:0]   read_addr,
  input  logic                bp_enable,
  input  logic                resume_req,
  output logic                halted,
  output logic [BP_IDX_W-1:0] hit_index
);

  logic [1:0]          state;
  logic [ADDR_W-1:0]   stop_addr;                   // where the stop hit
  logic                any_match;
  logic [BP_IDX_W-1:0] first_idx;                   // lowest matching slot
  logic                take_hit;

  // walk downwards so the lowest index wins
  always_comb begin
    first_idx = '0;
    for (int i = NUM_BP - 1; i >= 0; i--) begin
      if (match[i]) first_idx = BP_IDX_W'(i);
    end
  end

  assign any_match = |match;
  assign take_hit  = (state == XRAY_RUN) && read_strobe && bp_enable && any_match;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= XRAY_RUN;
      hit_index <= '0;
    end else begin
      case (state)
        XRAY_RUN: begin
          if (take_hit) begin
            state     <= XRAY_STOP;
            hit_index <= first_idx;
          end
        end
        XRAY_STOP: begin
          if (resume_req) state <= XRAY_RESUME;     // host done with stub
        end
        XRAY_RESUME: begin
          // back to run once the cpu refetches the stop address
          if (read_strobe && read_addr == stop_addr) state <= XRAY_RUN;
        end
        default: state <= XRAY_RUN;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take_hit) stop_addr <= read_addr;
  end

  assign halted = (state != XRAY_RUN);

  a_no_state2: assert property (@(posedge clk) disable iff (!rst_n)
    state != 2'd2);

endmodule

// File: breakpoint_slot.sv
module breakpoint_slot import trs_dbg_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [BP_IDX_W-1:0] slot_id,
  input  logic                bp_set,
  input  logic                bp_clear,
  input  logic [BP_IDX_W-1:0] bp_sel,
  input  logic [ADDR_W-1:0]   bp_addr,
  input  logic [ADDR_W-1:0]   read_addr,
  output logic                match
);

  logic              selected;
  logic              active;
  logic [ADDR_W-1:0] bp_addr_q;                     // watched address

  assign selected = (bp_sel == slot_id);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active <= 1'b0;
    end else if (selected) begin
      if (bp_set) active <= 1'b1;
      else if (bp_clear) active <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (selected && bp_set) bp_addr_q <= bp_addr;
  end

  // only meaningful while read_strobe is up
  assign match = active && (bp_addr_q == read_addr);

endmodule

// File: cmd_decoder.sv
module cmd_decoder import trs_dbg_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [BYTE_W-1:0]   rx_byte,
  input  logic                rx_valid,
  input  logic                frame_start,
  input  logic [ADDR_W-1:0]   read_addr,
  output logic [BYTE_W-1:0]   tx_byte,
  output logic                tx_load,
  output logic                bp_set,
  output logic                bp_clear,
  output logic [BP_IDX_W-1:0] bp_sel,
  output logic [ADDR_W-1:0]   bp_addr,
  output logic                bp_enable,
  output logic                resume_req
);

  logic              collecting;                    // 0 idle, 1 collect params
  logic [1:0]        remaining;                     // param bytes still due
  logic              is_set;                        // set_bp, else clear_bp
  logic              resp_skip;                     // next byte is the response slot
  logic              cmd_byte;                      // rx byte is a command code
  logic              param_byte;
  logic              has_resp;
  logic [BYTE_W-1:0] resp_byte;

  assign cmd_byte   = rx_valid && !frame_start && !resp_skip && !collecting;
  assign param_byte = rx_valid && !frame_start && collecting;

  // response for one-byte queries
  always_comb begin
    has_resp  = 1'b1;
    resp_byte = '0;
    case (rx_byte)
      CMD_GET_COOKIE:  resp_byte = COOKIE;
      CMD_GET_VERSION: resp_byte = {VERSION_MAJOR, VERSION_MINOR};
      CMD_ABUS_READ:   resp_byte = read_addr[BYTE_W-1:0];   // last bus read
      default:         has_resp  = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      collecting <= 1'b0;
      remaining  <= '0;
      is_set     <= 1'b0;
      resp_skip  <= 1'b0;
      tx_load    <= 1'b0;
      bp_set     <= 1'b0;
      bp_clear   <= 1'b0;
      bp_enable  <= 1'b0;
      resume_req <= 1'b0;
    end else begin
      tx_load    <= 1'b0;
      bp_set     <= 1'b0;
      bp_clear   <= 1'b0;
      resume_req <= 1'b0;
      if (frame_start) begin
        collecting <= 1'b0;                         // abort partial command
        resp_skip  <= 1'b0;
      end else if (rx_valid && resp_skip) begin
        resp_skip <= 1'b0;                          // dummy byte under response
      end else if (cmd_byte) begin
        tx_load   <= has_resp;
        resp_skip <= has_resp;
        case (rx_byte)
          CMD_ENABLE_BP:  bp_enable  <= 1'b1;
          CMD_DISABLE_BP: bp_enable  <= 1'b0;
          CMD_RESUME:     resume_req <= 1'b1;
          CMD_SET_BP: begin
            collecting <= 1'b1;
            remaining  <= 2'd3;                     // slot, lo, hi
            is_set     <= 1'b1;
          end
          CMD_CLEAR_BP: begin
            collecting <= 1'b1;
            remaining  <= 2'd1;                     // slot only
            is_set     <= 1'b0;
          end
          default: ;                                // unknown or query, stay idle
        endcase
      end else if (param_byte) begin
        remaining <= remaining - 1'b1;
        if (remaining == 2'd1) begin
          collecting <= 1'b0;
          bp_set     <= is_set;
          bp_clear   <= !is_set;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_byte && has_resp) tx_byte <= resp_byte;
  end

  // parameter register, slot and address assembled byte by byte
  always_ff @(posedge clk) begin
    if (param_byte) begin
      if (!is_set || remaining == 2'd3) bp_sel <= rx_byte[BP_IDX_W-1:0];
      else if (remaining == 2'd2) bp_addr[BYTE_W-1:0] <= rx_byte;
      else bp_addr[ADDR_W-1:BYTE_W] <= rx_byte;
    end
  end

  a_set_clear_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(bp_set && bp_clear));

endmodule

// File: spi_byte_link.sv
module spi_byte_link import trs_dbg_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              sck,
  input  logic              cs_n,
  input  logic              mosi,
  input  logic [BYTE_W-1:0] tx_byte,
  input  logic              tx_load,
  output logic [BYTE_W-1:0] rx_byte,
  output logic              rx_valid,
  output logic              frame_start,
  output logic              miso
);

  // one extra stage on sck and cs_n for edge detection
  logic [SYNC_STAGES:0]   sck_q;
  logic [SYNC_STAGES:0]   cs_q;
  logic [SYNC_STAGES-1:0] mosi_q;
  logic                   sck_s, cs_s, mosi_s;
  logic                   sck_rise, sck_fall;
  logic                   cs_fall;
  logic                   cs_active;

  logic [$clog2(BYTE_W)-1:0] bit_cnt;               // bits of current rx byte
  logic [BYTE_W-1:0]         rx_shift;
  logic [BYTE_W-1:0]         tx_shift;              // response, msb first
  logic                      miso_q;

  assign sck_s  = sck_q[SYNC_STAGES-1];
  assign cs_s   = cs_q[SYNC_STAGES-1];
  assign mosi_s = mosi_q[SYNC_STAGES-1];

  assign sck_rise  = sck_s && !sck_q[SYNC_STAGES];
  assign sck_fall  = !sck_s && sck_q[SYNC_STAGES];
  assign cs_fall   = !cs_s && cs_q[SYNC_STAGES];
  assign cs_active = !cs_s;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sck_q <= '0;
      cs_q  <= '1;                                  // deselected
    end else begin
      sck_q <= {sck_q[SYNC_STAGES-1:0], sck};
      cs_q  <= {cs_q[SYNC_STAGES-1:0], cs_n};
    end
  end

  always_ff @(posedge clk) begin
    mosi_q <= {mosi_q[SYNC_STAGES-2:0], mosi};      // aligned with sck_q
  end

  // receive side
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bit_cnt     <= '0;
      rx_valid    <= 1'b0;
      frame_start <= 1'b0;
    end else begin
      frame_start <= cs_fall;
      rx_valid    <= 1'b0;
      if (cs_fall || !cs_active) begin
        bit_cnt <= '0;                              // new frame restarts byte
      end else if (sck_rise) begin
        bit_cnt  <= bit_cnt + 1'b1;                 // wraps after 8 bits
        rx_valid <= (bit_cnt == BYTE_W - 1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) rx_shift <= {rx_shift[BYTE_W-2:0], mosi_s};
  end

  assign rx_byte = rx_shift;

  // transmit side, bit goes out on sck fall, master samples on rise
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_shift <= '0;
      miso_q   <= 1'b0;
    end else if (cs_fall) begin
      tx_shift <= '0;                               // drop leftovers of old frame
      miso_q   <= 1'b0;
    end else if (tx_load) begin
      tx_shift <= tx_byte;
    end else if (cs_active && sck_fall) begin
      miso_q   <= tx_shift[BYTE_W-1];
      tx_shift <= {tx_shift[BYTE_W-2:0], 1'b0};
    end
  end

  assign miso = cs_active ? miso_q : 1'b0;          // low, never z, outside frame

  // bytes only complete inside a frame
  a_rx_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
    rx_valid |-> !cs_s);

endmodule

// File: bus_access_filter.sv
module bus_access_filter import trs_dbg_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [ADDR_W-1:0] addr,
  input  logic              rd_n,
  output logic              read_strobe,
  output logic [ADDR_W-1:0] read_addr
);

  logic [SYNC_STAGES-1:0] rd_q;                     // rd_n synchronizer
  logic [ADDR_W-1:0]      addr_q [SYNC_STAGES];     // addr synchronizer
  logic                   rd_s;
  logic [FILTER_LEN-2:0]  hist;                     // older rd samples
  logic [FILTER_LEN-1:0]  window;
  logic                   reading;                  // filtered level, 1 = read cycle

  assign rd_s   = rd_q[SYNC_STAGES-1];
  assign window = {hist, rd_s};                     // newest sample included

  always_ff @(posedge clk) begin
    addr_q[0] <= addr;
    for (int i = 1; i < SYNC_STAGES; i++) begin
      addr_q[i] <= addr_q[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_q        <= '1;                            // bus idle
      hist        <= '1;
      reading     <= 1'b0;
      read_strobe <= 1'b0;
    end else begin
      rd_q        <= {rd_q[SYNC_STAGES-2:0], rd_n};
      hist        <= {hist[FILTER_LEN-3:0], rd_s};
      read_strobe <= 1'b0;
      if (window == '0) begin
        reading     <= 1'b1;
        read_strobe <= !reading;                    // only on entry
      end else if (&window) begin
        reading <= 1'b0;
      end
    end
  end

  // address of the cycle, taken together with the strobe
  always_ff @(posedge clk) begin
    if (window == '0 && !reading) read_addr <= addr_q[SYNC_STAGES-1];
  end

  // one strobe per read cycle
  a_strobe_single: assert property (@(posedge clk) disable iff (!rst_n)
    read_strobe |=> !read_strobe);

endmodule

// File: trs_dbg_pkg.sv
package trs_dbg_pkg;

  // bus and link widths
  localparam int ADDR_W   = 16;   // z80 address bus
  localparam int BYTE_W   = 8;    // spi byte, data byte
  localparam int NUM_BP   = 8;    // breakpoint slots
  localparam int BP_IDX_W = 3;    // slot index

  // input conditioning
  localparam int SYNC_STAGES = 2; // flops per async input
  localparam int FILTER_LEN  = 3; // equal samples before rd level is taken

  // identification
  localparam logic [BYTE_W-1:0] COOKIE        = 8'haf;
  localparam logic [2:0]        VERSION_MAJOR = 3'd0;
  localparam logic [4:0]        VERSION_MINOR = 5'd3;

  // host command codes, same numbering as the full board firmware
  localparam logic [BYTE_W-1:0] CMD_GET_COOKIE  = 8'd0;
  localparam logic [BYTE_W-1:0] CMD_SET_BP      = 8'd6;  // + slot, addr lo, addr hi
  localparam logic [BYTE_W-1:0] CMD_CLEAR_BP    = 8'd7;  // + slot
  localparam logic [BYTE_W-1:0] CMD_ENABLE_BP   = 8'd11;
  localparam logic [BYTE_W-1:0] CMD_DISABLE_BP  = 8'd12;
  localparam logic [BYTE_W-1:0] CMD_RESUME      = 8'd13;
  localparam logic [BYTE_W-1:0] CMD_GET_VERSION = 8'd15;
  localparam logic [BYTE_W-1:0] CMD_ABUS_READ   = 8'd18;

  // stepping states, code 2 unused
  localparam logic [1:0] XRAY_RUN    = 2'd0;
  localparam logic [1:0] XRAY_STOP   = 2'd1;
  localparam logic [1:0] XRAY_RESUME = 2'd3;

endpackage
